// File: mesi_snoop.f
+incdir+src
src/mesi_pkg.sv
src/bus_arbiter.sv
src/txn_fifo.sv
src/coherency_unit.sv
src/mesi_snoop_top.sv
sim/tb_clock_gen.sv
sim/tb_mesi_snoop.sv

// File: Bender.yml
package:
  name: mesi_snoop

sources:
  - include_dirs:
      - src
    files:
      - src/mesi_pkg.sv
      - src/bus_arbiter.sv
      - src/txn_fifo.sv
      - src/coherency_unit.sv
      - src/mesi_snoop_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_mesi_snoop.sv

// File: sim/tb_mesi_snoop.sv
/*
 * Testbench for the MESI snoop controller
 * Table of requests and expected responses, applied row by row, with a
 * reference model of the line-state table for the random rows
 */
`default_nettype none
`include "mesi_defines.svh"

module tb_mesi_snoop
    import mesi_pkg::*;
();

    localparam int          CPUS     = `MESI_CPUS;
    localparam int          AW       = `MESI_ADDR_W;
    localparam int          ROW_WAIT = 20;           // Cycles allowed per row
    localparam int          N_RANDOM = 10;
    localparam logic [31:0] SEED     = 32'h9fec7f3c;
    localparam logic [AW-1:0] ADDR_A = 'h100;        // Set 0
    localparam logic [AW-1:0] ADDR_B = 'h108;        // Set 0 with another tag
    localparam logic [AW-1:0] ADDR_D = 'h305;        // Set 5

    // One table row with entries indexed by CPU
    typedef struct packed {
        logic [CPUS-1:0]                  mask;   // CPUs strobing together
        bus_op_t [CPUS-1:0]               op;
        logic [CPUS-1:0][AW-1:0]          addr;
        mesi_state_t [CPUS-1:0]           st;     // Expected resp_state
        logic [CPUS-1:0][CPUS-1:0]        inv;
        logic [CPUS-1:0][CPUS-1:0]        share;
        logic [CPUS-1:0]                  wen;
        logic [CPUS-1:0][AW-1:0]          l2a;    // Checked only with wen
    } row_t;

    logic                    CLK;
    logic                    nRST;
    logic [CPUS-1:0]         req_valid;
    bus_op_t [CPUS-1:0]      req_op;
    logic [CPUS-1:0][AW-1:0] req_addr;
    logic [CPUS-1:0]         cpu_busy;
    logic                    resp_valid;
    cpu_idx_t                resp_cpu;
    mesi_state_t             resp_state;
    logic [CPUS-1:0]         snoop_inv;
    logic [CPUS-1:0]         snoop_share;
    logic                    l2_wen;
    logic [AW-1:0]           l2_addr;

    row_t        rows [$];
    string       names [$];
    int          value_errs  = 0;
    int          proto_errs  = 0;  // Missing, unexpected or busy faults
    int          cycles      = 0;
    int          cycle_limit = 0;
    logic [AW-1:0] m_tag [`MESI_SETS];          // Reference table
    mesi_state_t   m_st  [`MESI_SETS][CPUS];

    tb_clock_gen #(.PERIOD(100), .RST_CYCLES(2)) u_clk (.CLK(CLK), .nRST(nRST));

    mesi_snoop_top u_dut (
        .CLK(CLK), .nRST(nRST),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
        .cpu_busy(cpu_busy), .resp_valid(resp_valid), .resp_cpu(resp_cpu),
        .resp_state(resp_state), .snoop_inv(snoop_inv), .snoop_share(snoop_share),
        .l2_wen(l2_wen), .l2_addr(l2_addr)
    );

    // Appends a request to the last row or opens a new row on a non-empty name
    task automatic add_req(input string name, input int c, input bus_op_t op,
                           input logic [AW-1:0] addr, input mesi_state_t st,
                           input logic [CPUS-1:0] inv, input logic [CPUS-1:0] share,
                           input logic wen, input logic [AW-1:0] l2a);
        row_t r;
        if (name != "") begin
            rows.push_back('0);
            names.push_back(name);
        end
        r          = rows[rows.size()-1];
        r.mask[c]  = 1'b1;
        r.op[c]    = op;
        r.addr[c]  = addr;
        r.st[c]    = st;
        r.inv[c]   = inv;
        r.share[c] = share;
        r.wen[c]   = wen;
        r.l2a[c]   = l2a;
        rows[rows.size()-1] = r;
    endtask

    // One MESI step on the reference table
    task automatic ref_step(input int c, input bus_op_t op, input logic [AW-1:0] addr,
                            output mesi_state_t st, output logic [CPUS-1:0] inv,
                            output logic [CPUS-1:0] share, output logic wen,
                            output logic [AW-1:0] l2a);
        int            s;
        logic [AW-1:0] tag;
        logic          live;
        logic          others;
        s      = addr % `MESI_SETS;
        tag    = addr / `MESI_SETS;
        st     = INVALID;
        inv    = '0;
        share  = '0;
        wen    = 1'b0;
        l2a    = addr;
        live   = 1'b0;
        others = 1'b0;
        for (int i = 0; i < CPUS; i++)
            if (m_st[s][i] != INVALID) live = 1'b1;
        if (op == BUS_EVICT) begin
            if (live && m_tag[s] == tag) begin  // Only the requester's copy goes
                wen        = (m_st[s][c] == MODIFIED);
                m_st[s][c] = INVALID;
            end
        end else begin
            if (live && m_tag[s] != tag) begin  // Displace the old line
                l2a = m_tag[s] * `MESI_SETS + s;
                for (int i = 0; i < CPUS; i++) begin
                    if (m_st[s][i] != INVALID) begin
                        inv[i]     = 1'b1;
                        wen        = wen | (m_st[s][i] == MODIFIED);
                        m_st[s][i] = INVALID;
                    end
                end
            end
            m_tag[s] = tag;
            for (int i = 0; i < CPUS; i++)
                if (i != c && m_st[s][i] != INVALID) others = 1'b1;
            if (op == BUS_RD && m_st[s][c] != INVALID) begin
                st = m_st[s][c];               // Hit in own cache leaves the line alone
            end else if (op == BUS_RD && others) begin
                for (int i = 0; i < CPUS; i++) begin
                    if (m_st[s][i] != INVALID) begin
                        if (m_st[s][i] == MODIFIED) begin
                            wen = 1'b1;
                            l2a = addr;
                        end
                        m_st[s][i] = SHARED;
                        share[i]   = 1'b1;
                    end
                end
                st = SHARED;
            end else if (op == BUS_RD) begin
                st = EXCLUSIVE;
            end else begin                     // Read for ownership
                for (int i = 0; i < CPUS; i++) begin
                    if (i != c && m_st[s][i] != INVALID) begin
                        if (m_st[s][i] == MODIFIED) begin
                            wen = 1'b1;
                            l2a = addr;
                        end
                        inv[i]     = 1'b1;
                        m_st[s][i] = INVALID;
                    end
                end
                st = MODIFIED;
            end
            m_st[s][c] = st;
        end
    endtask

    // Hand-worked rows with the dual strobe first so CPU 0 wins right after reset
    task automatic build_directed();
        add_req("dual_strobe", 0, BUS_RD,  ADDR_D, EXCLUSIVE, 2'b00, 2'b00, 1'b0, '0);
        add_req("",            1, BUS_RDX, ADDR_D, MODIFIED,  2'b01, 2'b00, 1'b0, '0);
        add_req("cold_read",      0, BUS_RD,    ADDR_A, EXCLUSIVE, 2'b00, 2'b00, 1'b0, '0);
        add_req("read_shared",    1, BUS_RD,    ADDR_A, SHARED,    2'b00, 2'b01, 1'b0, '0);
        add_req("rdx_over_share", 0, BUS_RDX,   ADDR_A, MODIFIED,  2'b10, 2'b00, 1'b0, '0);
        add_req("read_from_dirty",1, BUS_RD,    ADDR_A, SHARED,    2'b00, 2'b01, 1'b1, ADDR_A);
        add_req("rdx_take_line",  1, BUS_RDX,   ADDR_A, MODIFIED,  2'b01, 2'b00, 1'b0, '0);
        add_req("evict_dirty",    1, BUS_EVICT, ADDR_A, INVALID,   2'b00, 2'b00, 1'b1, ADDR_A);
        add_req("read_again",     0, BUS_RD,    ADDR_A, EXCLUSIVE, 2'b00, 2'b00, 1'b0, '0);
        add_req("evict_clean",    0, BUS_EVICT, ADDR_A, INVALID,   2'b00, 2'b00, 1'b0, '0);
        add_req("rdx_fresh",      0, BUS_RDX,   ADDR_A, MODIFIED,  2'b00, 2'b00, 1'b0, '0);
        add_req("evict_tag_miss", 1, BUS_EVICT, ADDR_B, INVALID,   2'b00, 2'b00, 1'b0, '0);
        add_req("conflict_dirty", 1, BUS_RD,    ADDR_B, EXCLUSIVE, 2'b01, 2'b00, 1'b1, ADDR_A);
        add_req("conflict_clean", 0, BUS_RDX,   ADDR_A, MODIFIED,  2'b10, 2'b00, 1'b0, '0);
    endtask

    // Brings the reference table up to date in ascending CPU order within a row
    task automatic prime_model();
        mesi_state_t     st;
        logic [CPUS-1:0] inv;
        logic [CPUS-1:0] share;
        logic            wen;
        logic [AW-1:0]   l2a;
        for (int s = 0; s < `MESI_SETS; s++) begin
            m_tag[s] = '0;
            for (int i = 0; i < CPUS; i++) m_st[s][i] = INVALID;
        end
        foreach (rows[k])
            for (int c = 0; c < CPUS; c++)
                if (rows[k].mask[c])
                    ref_step(c, rows[k].op[c], rows[k].addr[c], st, inv, share, wen, l2a);
    endtask

    // Random single-CPU rows over two sets with two tags each
    task automatic build_random(input int n);
        int              c;
        bus_op_t         op;
        logic [AW-1:0]   addr;
        mesi_state_t     st;
        logic [CPUS-1:0] inv;
        logic [CPUS-1:0] share;
        logic            wen;
        logic [AW-1:0]   l2a;
        for (int k = 0; k < n; k++) begin
            c    = $urandom % CPUS;
            op   = bus_op_t'($urandom % 3);
            addr = (32'h20 + $urandom % 2) * `MESI_SETS + ($urandom % 2) * 3;
            ref_step(c, op, addr, st, inv, share, wen, l2a);
            add_req($sformatf("random_%0d", k), c, op, addr, st, inv, share, wen, l2a);
        end
    endtask

    task automatic check_val(input string test, input string field,
                             input logic [AW-1:0] exp, input logic [AW-1:0] act);
        assert (act === exp) else begin
            value_errs++;
            $display("Error: %s %s expected %0h actual %0h", test, field, exp, act);
        end
    endtask

    task automatic check_resp(input int k, input int c);
        row_t  r;
        string test;
        r    = rows[k];
        test = $sformatf("%s cpu%0d", names[k], c);
        check_val(test, "resp_state", r.st[c], resp_state);
        check_val(test, "snoop_inv", r.inv[c], snoop_inv);
        check_val(test, "snoop_share", r.share[c], snoop_share);
        check_val(test, "l2_wen", r.wen[c], l2_wen);
        if (r.wen[c])
            check_val(test, "l2_addr", r.l2a[c], l2_addr);
    endtask

    // Run limit from the table length
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: no end of test after %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int              c;
        int              waited;
        logic [CPUS-1:0] answered;
        row_t            r;
        req_valid = '0;
        for (int i = 0; i < CPUS; i++)
            req_op[i] = BUS_RD;
        req_addr  = '0;
        void'($urandom(SEED));
        build_directed();
        prime_model();
        build_random(N_RANDOM);
        cycle_limit = rows.size() * ROW_WAIT + 50;
        wait (nRST === 1'b1);
        foreach (rows[k]) begin
            r = rows[k];
            @(posedge CLK);
            req_valid <= r.mask;  // One-cycle strobe
            req_op    <= r.op;
            req_addr  <= r.addr;
            @(posedge CLK);
            req_valid <= '0;
            answered = '0;
            waited   = 0;
            while (answered != r.mask && waited < ROW_WAIT) begin
                @(negedge CLK);
                waited++;
                for (int i = 0; i < CPUS; i++)
                    if (r.mask[i] && !answered[i])
                        assert (cpu_busy[i]) else begin
                            proto_errs++;
                            $display("%s: cpu %0d not busy while its request is open",
                                     names[k], i);
                        end
                if (resp_valid) begin
                    c = int'(resp_cpu);
                    assert (r.mask[c] && !answered[c]) else begin
                        proto_errs++;
                        $display("%s: unexpected response for cpu %0d", names[k], c);
                    end
                    if (r.mask[c] && !answered[c]) begin
                        check_resp(k, c);
                        answered[c] = 1'b1;
                    end
                end
            end
            assert (answered == r.mask) else begin
                proto_errs++;
                $display("%s: response missing, got mask %b of %b", names[k], answered, r.mask);
            end
            @(negedge CLK);  // Answered CPUs are free again one cycle later
            assert (cpu_busy == '0) else begin
                proto_errs++;
                $display("%s: cpu_busy %b still set after the responses", names[k], cpu_busy);
            end
            assert (!resp_valid) else begin
                proto_errs++;
                $display("%s: resp_valid held past the last response", names[k]);
            end
        end
        $display("Checks done: %0d value errors, %0d protocol errors", value_errs, proto_errs);
        if (value_errs + proto_errs == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
/*
 * Testbench clock and reset generator
 * Free-running clock, active-low reset held for the first cycles
 */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 2
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;  // Rising edges at PERIOD/2, 3*PERIOD/2, ...
    end

    initial begin
        nRST = 1'b0;                      // In reset from time 0
        repeat (RST_CYCLES) @(posedge CLK);
        nRST <= 1'b1;                     // Released on a rising edge
    end

endmodule

`default_nettype wire

// File: src/mesi_snoop_top.sv
/*
 * MESI snoop controller top level
 * Arbiter feeds the transaction queue, the coherency unit drains it
 */
`default_nettype none
`include "mesi_defines.svh"

module mesi_snoop_top
    import mesi_pkg::*;
(
    input  wire logic                                    CLK,
    input  wire logic                                    nRST,
    input  wire logic [`MESI_CPUS-1:0]                   req_valid,
    input  wire bus_op_t [`MESI_CPUS-1:0]                req_op,
    input  wire logic [`MESI_CPUS-1:0][`MESI_ADDR_W-1:0] req_addr,
    output logic [`MESI_CPUS-1:0]                        cpu_busy,
    output logic                                         resp_valid,
    output cpu_idx_t                                     resp_cpu,
    output mesi_state_t                                  resp_state,
    output logic [`MESI_CPUS-1:0]                        snoop_inv,
    output logic [`MESI_CPUS-1:0]                        snoop_share,
    output logic                                         l2_wen,
    output logic [`MESI_ADDR_W-1:0]                      l2_addr
);

    logic     push;      // Arbiter grant into the queue
    bus_txn_t push_txn;
    logic     full;
    logic     empty;
    bus_txn_t head_txn;  // Oldest queued transaction
    logic     pop;

    bus_arbiter u_arbiter (
        .CLK        (CLK),
        .nRST       (nRST),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .full       (full),
        .resp_valid (resp_valid),  // Releases the answered CPU
        .resp_cpu   (resp_cpu),
        .cpu_busy   (cpu_busy),
        .push       (push),
        .push_txn   (push_txn)
    );

    txn_fifo #(
        .payload_t (bus_txn_t)
    ) u_fifo (
        .CLK       (CLK),
        .nRST      (nRST),
        .push      (push),
        .push_data (push_txn),
        .pop       (pop),
        .head_data (head_txn),
        .full      (full),
        .empty     (empty)
    );

    coherency_unit u_coherency (
        .CLK         (CLK),
        .nRST        (nRST),
        .empty       (empty),
        .head_txn    (head_txn),
        .pop         (pop),
        .resp_valid  (resp_valid),
        .resp_cpu    (resp_cpu),
        .resp_state  (resp_state),
        .snoop_inv   (snoop_inv),
        .snoop_share (snoop_share),
        .l2_wen      (l2_wen),
        .l2_addr     (l2_addr)
    );

endmodule

`default_nettype wire

// File: src/coherency_unit.sv
/*
 * MESI coherency unit
 * Per-set line-state table, one tag and one state per CPU, updated from the
 * head transaction with snoop masks, requester grant and write-back request
 */
`default_nettype none
`include "mesi_defines.svh"

module coherency_unit
    import mesi_pkg::*;
(
    input  wire logic                 CLK,
    input  wire logic                 nRST,
    input  wire logic                 empty,
    input  wire bus_txn_t             head_txn,
    output logic                      pop,
    output logic                      resp_valid,
    output cpu_idx_t                  resp_cpu,
    output mesi_state_t               resp_state,
    output logic [`MESI_CPUS-1:0]     snoop_inv,
    output logic [`MESI_CPUS-1:0]     snoop_share,
    output logic                      l2_wen,
    output logic [`MESI_ADDR_W-1:0]   l2_addr
);

    localparam int SET_W = $clog2(`MESI_SETS);
    localparam int TAG_W = `MESI_ADDR_W - SET_W;

    typedef mesi_state_t [`MESI_CPUS-1:0] line_t;  // One state per CPU

    logic [TAG_W-1:0] tag_tbl   [`MESI_SETS];
    line_t            state_tbl [`MESI_SETS];

    logic [SET_W-1:0]          set_idx;
    logic [TAG_W-1:0]          req_tag;
    cpu_idx_t                  req_cpu;
    line_t                     cur_line;
    logic                      line_live;  // Some CPU holds the stored tag
    logic                      tag_hit;

    line_t                     nxt_line;
    logic [TAG_W-1:0]          nxt_tag;
    mesi_state_t               nxt_state;  // Requester's grant
    logic [`MESI_CPUS-1:0]     nxt_inv;
    logic [`MESI_CPUS-1:0]     nxt_share;
    logic                      nxt_wb;
    logic [`MESI_ADDR_W-1:0]   nxt_wb_addr;

    assign pop = !empty;  // One transaction per cycle

    assign set_idx  = head_txn.addr[SET_W-1:0];
    assign req_tag  = head_txn.addr[`MESI_ADDR_W-1:SET_W];
    assign req_cpu  = head_txn.cpu;
    assign cur_line = state_tbl[set_idx];
    assign tag_hit  = (tag_tbl[set_idx] == req_tag);

    always_comb begin
        line_live = 1'b0;
        for (int i = 0; i < `MESI_CPUS; i++)
            if (cur_line[i] != INVALID)
                line_live = 1'b1;
    end

    // MESI transaction step
    always_comb begin
        logic other_held;
        nxt_line    = cur_line;
        nxt_tag     = tag_tbl[set_idx];
        nxt_state   = INVALID;
        nxt_inv     = '0;
        nxt_share   = '0;
        nxt_wb      = 1'b0;
        nxt_wb_addr = head_txn.addr;  // Request's own line unless displaced
        other_held  = 1'b0;

        // Miss on another tag in this set pushes the old line out first
        if (head_txn.op != BUS_EVICT) begin
            nxt_tag = req_tag;
            if (line_live && !tag_hit) begin
                nxt_wb_addr = {tag_tbl[set_idx], set_idx};  // Old line's address
                for (int i = 0; i < `MESI_CPUS; i++) begin
                    if (cur_line[i] != INVALID) begin
                        nxt_inv[i]  = 1'b1;
                        nxt_wb      = nxt_wb || (cur_line[i] == MODIFIED);
                        nxt_line[i] = INVALID;
                    end
                end
            end
        end

        for (int i = 0; i < `MESI_CPUS; i++)
            if (cpu_idx_t'(i) != req_cpu && nxt_line[i] != INVALID)
                other_held = 1'b1;

        case (head_txn.op)
            BUS_RD: begin
                if (nxt_line[req_cpu] != INVALID) begin
                    nxt_state = nxt_line[req_cpu];  // Already a holder
                end else if (other_held) begin
                    for (int i = 0; i < `MESI_CPUS; i++) begin
                        if (nxt_line[i] != INVALID) begin
                            if (nxt_line[i] == MODIFIED)
                                nxt_wb = 1'b1;  // Owner flushes dirty copy
                            nxt_line[i]  = SHARED;
                            nxt_share[i] = 1'b1;
                        end
                    end
                    nxt_state = SHARED;
                end else begin
                    nxt_state = EXCLUSIVE;  // Sole copy
                end
                nxt_line[req_cpu] = nxt_state;
            end
            BUS_RDX: begin
                for (int i = 0; i < `MESI_CPUS; i++) begin
                    if (cpu_idx_t'(i) != req_cpu && nxt_line[i] != INVALID) begin
                        if (nxt_line[i] == MODIFIED)
                            nxt_wb = 1'b1;  // Dirty owner writes back
                        nxt_inv[i]  = 1'b1;
                        nxt_line[i] = INVALID;
                    end
                end
                nxt_state         = MODIFIED;
                nxt_line[req_cpu] = MODIFIED;
            end
            BUS_EVICT: begin
                if (line_live && tag_hit) begin  // Mismatching tag leaves the set alone
                    nxt_wb            = (cur_line[req_cpu] == MODIFIED);
                    nxt_line[req_cpu] = INVALID;
                end
            end
            default: ;  // Unused encoding
        endcase
    end

    // Table states and response strobes
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            resp_valid  <= 1'b0;
            l2_wen      <= 1'b0;
            snoop_inv   <= '0;
            snoop_share <= '0;
            for (int s = 0; s < `MESI_SETS; s++)
                for (int i = 0; i < `MESI_CPUS; i++)
                    state_tbl[s][i] <= INVALID;
        end else begin
            resp_valid  <= pop;
            l2_wen      <= pop && nxt_wb;
            snoop_inv   <= pop ? nxt_inv : '0;    // Masks only in the response cycle
            snoop_share <= pop ? nxt_share : '0;
            if (pop)
                state_tbl[set_idx] <= nxt_line;
        end
    end

    // Tags and response payload
    always_ff @(posedge CLK) begin
        if (pop) begin
            tag_tbl[set_idx] <= nxt_tag;
            resp_cpu         <= req_cpu;
            resp_state       <= nxt_state;
            l2_addr          <= nxt_wb_addr;
        end
    end

endmodule

`default_nettype wire

// File: src/txn_fifo.sv
/*
 * Synchronous transaction queue
 * Circular buffer with a parameterized payload type between arbiter and
 * coherency unit, push and pop together are accepted when full
 */
`default_nettype none
`include "mesi_defines.svh"

module txn_fifo
    import mesi_pkg::*;
#(
    parameter type payload_t = bus_txn_t
) (
    input  wire logic     CLK,
    input  wire logic     nRST,
    input  wire logic     push,
    input  wire payload_t push_data,
    input  wire logic     pop,
    output payload_t      head_data,
    output logic          full,
    output logic          empty
);

    localparam int DEPTH = `MESI_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;  // Entries held
    logic             do_push;
    logic             do_pop;

    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);  // Pop frees the slot this cycle

    assign full      = (count == FULL_CNT);
    assign empty     = (count == '0);
    assign head_data = mem[rd_ptr];  // Head visible right after the push edge

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // Storage
    always_ff @(posedge CLK) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

endmodule

`default_nettype wire

// File: src/bus_arbiter.sv
/*
 * Round-robin bus arbiter
 * Latches one request strobe per CPU and grants one pending slot per cycle
 * into the transaction queue, holding busy until the CPU is answered
 */
`default_nettype none
`include "mesi_defines.svh"

module bus_arbiter
    import mesi_pkg::*;
(
    input  wire logic                                    CLK,
    input  wire logic                                    nRST,
    input  wire logic [`MESI_CPUS-1:0]                   req_valid,
    input  wire bus_op_t [`MESI_CPUS-1:0]                req_op,
    input  wire logic [`MESI_CPUS-1:0][`MESI_ADDR_W-1:0] req_addr,
    input  wire logic                                    full,
    input  wire logic                                    resp_valid,
    input  wire cpu_idx_t                                resp_cpu,
    output logic [`MESI_CPUS-1:0]                        cpu_busy,
    output logic                                         push,
    output bus_txn_t                                     push_txn
);

    localparam cpu_idx_t LAST_CPU = cpu_idx_t'(`MESI_CPUS - 1);

    logic [`MESI_CPUS-1:0]                   pend_valid; // Slot waiting for the queue
    bus_op_t [`MESI_CPUS-1:0]                pend_op;
    logic [`MESI_CPUS-1:0][`MESI_ADDR_W-1:0] pend_addr;
    cpu_idx_t                                rr_ptr;     // First CPU looked at this cycle
    cpu_idx_t                                grant_idx;
    logic                                    grant_found;

    // Scan pending slots starting at the round-robin pointer
    always_comb begin
        int slot;
        grant_found = 1'b0;
        grant_idx   = rr_ptr;
        for (int k = 0; k < `MESI_CPUS; k++) begin
            slot = (int'(rr_ptr) + k) % `MESI_CPUS;
            if (!grant_found && pend_valid[slot]) begin
                grant_found = 1'b1;
                grant_idx   = cpu_idx_t'(slot);
            end
        end
    end

    assign push = grant_found && !full;  // Hold off while the queue is full

    always_comb begin
        push_txn.op   = pend_op[grant_idx];
        push_txn.cpu  = grant_idx;
        push_txn.addr = pend_addr[grant_idx];
    end

    // Pending and busy flags, pointer
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pend_valid <= '0;
            cpu_busy   <= '0;
            rr_ptr     <= '0;  // CPU 0 goes first after reset
        end else begin
            for (int i = 0; i < `MESI_CPUS; i++) begin
                if (resp_valid && resp_cpu == cpu_idx_t'(i))
                    cpu_busy[i] <= 1'b0;  // Answered, CPU may issue again
                if (req_valid[i]) begin
                    pend_valid[i] <= 1'b1;
                    cpu_busy[i]   <= 1'b1;
                end else if (push && grant_idx == cpu_idx_t'(i)) begin
                    pend_valid[i] <= 1'b0;  // Slot moved into the queue
                end
            end
            if (push)
                rr_ptr <= (grant_idx == LAST_CPU) ? '0 : grant_idx + 1'b1;
        end
    end

    // Request payload, captured with the strobe
    always_ff @(posedge CLK) begin
        for (int i = 0; i < `MESI_CPUS; i++) begin
            if (req_valid[i]) begin
                pend_op[i]   <= req_op[i];
                pend_addr[i] <= req_addr[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/mesi_pkg.sv
/*
 * MESI snoop controller types
 * Line states, bus operations and the queued bus transaction
 */
`default_nettype none
`include "mesi_defines.svh"

package mesi_pkg;

    // CPU index width, kept at one bit for a single-CPU build
    localparam int CPU_W = (`MESI_CPUS > 1) ? $clog2(`MESI_CPUS) : 1;

    typedef logic [CPU_W-1:0] cpu_idx_t;

    // Line state held per CPU, INVALID is the reset value
    typedef enum logic [1:0] {
        MODIFIED,
        EXCLUSIVE,
        SHARED,
        INVALID
    } mesi_state_t;

    typedef enum logic [1:0] {
        BUS_RD,     // Read miss
        BUS_RDX,    // Write miss, read for ownership
        BUS_EVICT   // Line replaced in the requester's cache
    } bus_op_t;

    // One queued bus transaction
    typedef struct packed {
        bus_op_t                 op;
        cpu_idx_t                cpu;   // Requesting CPU
        logic [`MESI_ADDR_W-1:0] addr;  // Line address
    } bus_txn_t;

endpackage

`default_nettype wire

// File: src/mesi_defines.svh
/*
 * Build-time sizing for the MESI snoop controller
 * CPU count, line address width, line-state table sets and queue depth
 */
`ifndef MESI_DEFINES_SVH
`define MESI_DEFINES_SVH

// CPUs sharing the snoop bus
`define MESI_CPUS 2

// Cache-line address width
`define MESI_ADDR_W 32

// Sets in the line-state table, low address bits select the set
`define MESI_SETS 8

// Entries in the transaction queue
`define MESI_FIFO_DEPTH 4

`endif
